// File: bench/branch_core_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module branch_core_asserts (
	input wire logic                clk,
	input wire logic                rst,
	input wire logic                run,
	input wire logic                wb_cyc,
	input wire logic                wb_stb,
	input wire cpu_pkg::inst_addr_t wb_adr,
	input wire logic                wb_ack,
	input wire logic                retire_valid,
	input wire logic                rf_we         // Regfile write enable
);

	int failures; // Failed assertion count, read by the testbench

	initial failures = 0;

	// Cycle and strobe both close right after the ack
	assert property (@(posedge clk) disable iff (rst) wb_ack |=> (!wb_cyc && !wb_stb))
		else begin
			failures++;
			$error("bus cycle still open after ack");
		end

	// Address held while the slave inserts wait states
	assert property (@(posedge clk) disable iff (rst)
		(wb_cyc && !wb_ack) |=> (wb_adr == $past(wb_adr)))
		else begin
			failures++;
			$error("wb_adr changed before ack");
		end

	// EXEC is a single cycle
	assert property (@(posedge clk) disable iff (rst) retire_valid |=> !retire_valid)
		else begin
			failures++;
			$error("retire_valid held for two cycles");
		end

	// First cycle out of reset is quiet
	assert property (@(posedge clk) ($past(rst) && !rst) |-> (!wb_cyc && !retire_valid))
		else begin
			failures++;
			$error("bus or retire active right after reset");
		end

	// Only link writes while running, and those only in EXEC
	assert property (@(posedge clk) disable iff (rst) (rf_we && run) |-> retire_valid)
		else begin
			failures++;
			$error("regfile written outside EXEC while running");
		end

endmodule

bind branch_core branch_core_asserts u_asserts (
	.clk(clk), .rst(rst), .run(run),
	.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_ack(wb_ack),
	.retire_valid(retire_valid),
	.rf_we(rf_we)
);

`default_nettype wire

// File: bench/tb_branch_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_branch_core;

	logic clk, rst, run, cfg_we, wb_ack;
	cpu_pkg::reg_addr_t  cfg_addr;
	cpu_pkg::word_t      cfg_data, wb_dat_i;
	wire logic           wb_cyc, wb_stb, wb_we, retire_valid, retire_jump;
	wire logic [3:0]     wb_sel;
	wire cpu_pkg::inst_addr_t wb_adr, retire_pc, retire_target;
	wire cpu_pkg::inst_t retire_inst;

	cpu_pkg::inst_t      mem [256];    // Instruction memory, word indexed
	integer              seed;
	int                  wait_left;    // Wait states before next ack
	int                  draw;
	int                  value_errors, timeout_errors;
	cpu_pkg::word_t      mregs [32];   // Model register file
	cpu_pkg::inst_addr_t m_pc, m_pending;
	logic                m_delay;      // Model is in a delay slot

	branch_core #(.RESET_PC(32'h0000_0000)) dut (
		.clk(clk), .rst(rst), .run(run), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
		.cfg_data(cfg_data), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
		.wb_sel(wb_sel), .wb_we(wb_we), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_inst(retire_inst),
		.retire_jump(retire_jump), .retire_target(retire_target));

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Wishbone slave with 0 to 3 random wait states
	always @(negedge clk) begin
		if (wb_ack) begin
			wb_ack <= 1'b0; // Cycle ends after one ack
		end else if (wb_cyc && wb_stb) begin
			compare("wb_sel", wb_sel, 32'hf); // Full word reads only
			compare("wb_we", wb_we, 32'h0);
			if (wait_left == 0) begin
				wb_ack   <= 1'b1;
				wb_dat_i <= mem[wb_adr[9:2]];
				draw = $random(seed);
				wait_left <= draw[1:0];
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end

	function automatic cpu_pkg::inst_t enc_i(cpu_pkg::opcode_t op, int rs, int rt, int off);
		return {op, 5'(rs), 5'(rt), 16'(off)};
	endfunction

	function automatic cpu_pkg::inst_t enc_j(cpu_pkg::opcode_t op, int word_idx);
		return {op, 26'(word_idx)}; // Index is the word address
	endfunction

	function automatic cpu_pkg::inst_t enc_r(int rs, int rd, logic [5:0] fn);
		return {cpu_pkg::OP_SPECIAL, 5'(rs), 5'd0, 5'(rd), 5'd0, fn};
	endfunction

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic print_counts;
		$display("Error counts: %0d wrong values, %0d timeouts, %0d assertion failures",
			value_errors, timeout_errors, dut.u_asserts.failures);
	endtask

	// Rules applied to the retiring word, then model state moves on
	task automatic check_retire;
		cpu_pkg::inst_t      i;
		cpu_pkg::word_t      rs_v, rt_v;
		cpu_pkg::inst_addr_t seq, br_target, exp_target;
		logic                exp_jump, link;
		cpu_pkg::reg_addr_t  link_to;
		int                  off;          // Signed branch offset in words
		i = mem[m_pc[9:2]];
		rs_v = mregs[i[25:21]];
		rt_v = mregs[i[20:16]];
		seq = m_pc + 32'd4;
		off = $signed(i[15:0]);
		br_target = seq + off * 4;
		exp_jump = 1'b0;
		exp_target = br_target;
		link = 1'b0;
		link_to = 5'd31;
		if (!m_delay) begin // Slot branches do nothing
			case (i[31:26])
				cpu_pkg::OP_BEQ:  exp_jump = (rs_v == rt_v);
				cpu_pkg::OP_BNE:  exp_jump = (rs_v != rt_v);
				cpu_pkg::OP_BLEZ: exp_jump = ($signed(rs_v) <= 0);
				cpu_pkg::OP_BGTZ: exp_jump = ($signed(rs_v) > 0);
				cpu_pkg::OP_REGIMM: begin
					case (i[20:16])
						5'd0:  exp_jump = ($signed(rs_v) < 0);
						5'd1:  exp_jump = ($signed(rs_v) >= 0);
						5'd16: begin
							exp_jump = ($signed(rs_v) < 0);
							link = 1'b1;
						end
						5'd17: begin
							exp_jump = ($signed(rs_v) >= 0);
							link = 1'b1;
						end
						default: exp_jump = 1'b0;
					endcase
				end
				cpu_pkg::OP_J, cpu_pkg::OP_JAL: begin
					exp_jump = 1'b1;
					exp_target = (seq & 32'hf000_0000) | (i[25:0] * 32'd4); // Same 256MB region
					link = (i[31:26] == cpu_pkg::OP_JAL);
				end
				cpu_pkg::OP_SPECIAL: begin
					if (i[5:0] == cpu_pkg::FN_JR || i[5:0] == cpu_pkg::FN_JALR) begin
						exp_jump = 1'b1;
						exp_target = rs_v;
						link = (i[5:0] == cpu_pkg::FN_JALR);
						link_to = i[15:11];
					end
				end
				default: exp_jump = 1'b0;
			endcase
		end
		compare("retire_pc", retire_pc, m_pc);
		compare("retire_inst", retire_inst, i);
		compare("retire_jump", retire_jump, exp_jump);
		if (exp_jump) compare("retire_target", retire_target, exp_target);
		if (link && link_to != 5'd0) mregs[link_to] = m_pc + 32'd8; // Link even if untaken
		if (m_delay) begin
			m_pc = m_pending;
			m_delay = 1'b0;
		end else begin
			m_pc = seq;
			m_delay = exp_jump;
			if (exp_jump) m_pending = exp_target;
		end
	endtask

	task automatic wait_retire;
		int n;
		n = 0;
		@(negedge clk);
		while (!retire_valid && n < 40) begin
			@(negedge clk);
			n++;
		end
		if (!retire_valid) begin
			timeout_errors++;
			$display("No instruction retired within 40 cycles");
		end
	endtask

	// Retire until stop_pc, then return on that same falling edge
	task automatic run_until(cpu_pkg::inst_addr_t stop_pc, int limit);
		int count;
		count = 0;
		while (count < limit && timeout_errors == 0) begin
			wait_retire();
			if (timeout_errors != 0) break; // Core stalled
			check_retire();
			if (retire_pc == stop_pc) break;
			count++;
		end
		if (count >= limit) begin
			value_errors++;
			$display("Program never reached address %h", stop_pc);
		end
	endtask

	task automatic cfg_write(int r, cpu_pkg::word_t d);
		cfg_we = 1'b1;
		cfg_addr = 5'(r);
		cfg_data = d;
		if (r != 0 && !run) mregs[r] = d; // Dropped while running
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	initial begin
		seed = 32'h5cce_03b3;
		rst = 1'b1;
		run = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		wait_left = 0;
		value_errors = 0;
		timeout_errors = 0;
		m_pc = 32'h0;
		m_pending = 32'h0;
		m_delay = 1'b0;
		for (int k = 0; k < 32; k++) mregs[k] = '0;
		// Address-tagged ADDU words act as no-ops
		for (int k = 0; k < 256; k++) mem[k] = {6'd0, 12'd0, 8'(k), 6'h21};
		mem[0]  = enc_i(cpu_pkg::OP_BEQ, 1, 3, 5);      // Unequal, falls through
		mem[3]  = enc_i(cpu_pkg::OP_BEQ, 1, 2, 3);      // Taken to w7
		mem[7]  = enc_i(cpu_pkg::OP_BNE, 1, 2, 5);      // Equal, falls through
		mem[9]  = enc_i(cpu_pkg::OP_BLEZ, 4, 0, 2);     // Negative, to w12
		mem[10] = enc_i(cpu_pkg::OP_BGTZ, 1, 0, 20);    // In delay slot
		mem[12] = enc_i(cpu_pkg::OP_BGTZ, 5, 0, 4);     // Zero, falls through
		mem[13] = enc_i(cpu_pkg::OP_BLEZ, 5, 0, 1);     // Zero, to w15
		mem[15] = enc_i(cpu_pkg::OP_REGIMM, 4, 0, 1);   // BLTZ taken to w17
		mem[17] = enc_i(cpu_pkg::OP_REGIMM, 4, 1, 4);   // BGEZ untaken
		mem[18] = enc_i(cpu_pkg::OP_REGIMM, 1, 16, 9);  // BLTZAL untaken, r31 = 80
		mem[19] = enc_j(cpu_pkg::OP_J, 30);
		mem[21] = enc_j(cpu_pkg::OP_JAL, 33);           // r31 = 92, to w33
		mem[23] = enc_j(cpu_pkg::OP_J, 40);
		mem[30] = enc_i(cpu_pkg::OP_REGIMM, 1, 2, 9);   // Bits 19:17 set, no-op
		mem[31] = enc_r(31, 0, cpu_pkg::FN_JR);         // Back to w20
		mem[33] = enc_r(31, 0, cpu_pkg::FN_JR);         // Exposes JAL link, to w23
		mem[40] = enc_i(cpu_pkg::OP_REGIMM, 5, 17, 3);  // BGEZAL taken to w44
		mem[43] = enc_j(cpu_pkg::OP_J, 70);             // Slot holds the JALR
		mem[44] = enc_r(6, 8, cpu_pkg::FN_JALR);        // r8 = 184, to w50
		mem[47] = enc_j(cpu_pkg::OP_J, 60);
		mem[50] = enc_r(8, 0, cpu_pkg::FN_JR);          // Exposes r8
		mem[60] = enc_r(31, 0, cpu_pkg::FN_JR);         // Exposes BGEZAL link
		mem[75] = enc_i(cpu_pkg::OP_BNE, 1, 3, 1);      // Unequal, to w77
		mem[77] = enc_i(cpu_pkg::OP_BGTZ, 1, 0, 1);     // Positive, to w79
		mem[79] = enc_i(cpu_pkg::OP_BLEZ, 1, 0, 5);     // Positive, falls through
		mem[80] = enc_r(9, 0, cpu_pkg::FN_JR);          // Uses r9 set while stopped
		repeat (3) @(negedge clk);
		rst = 1'b0;
		cfg_write(1, 32'd5);
		cfg_write(2, 32'd5);
		cfg_write(3, 32'd7);
		cfg_write(4, 32'hffff_fffd);
		cfg_write(6, 32'd200);
		run = 1'b1;
		cfg_write(6, 32'd100);   // Ignored, JALR still goes to 200
		run_until(32'd296, 100); // w74
		run = 1'b0;
		repeat (6) begin
			@(negedge clk);
			if (retire_valid) begin
				value_errors++;
				$display("Instruction retired while the core was stopped");
			end
		end
		cfg_write(9, 32'd360);   // w90
		run = 1'b1;
		run_until(32'd368, 40);  // w92
		run = 1'b0;
		print_counts();
		if (value_errors == 0 && timeout_errors == 0 && dut.u_asserts.failures == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
rtl/cpu_pkg.sv
rtl/branch_if.sv
rtl/regfile.sv
rtl/branch.sv
rtl/wb_fetch.sv
rtl/pc_ctrl.sv
rtl/branch_core.sv
bench/branch_core_asserts.sv
bench/tb_branch_core.sv

// File: include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// All-zero data word
`define ZERO_WORD 32'h0000_0000

// Boot address of the sequencer
`define DEFAULT_RESET_PC 32'hbfc0_0000

// Byte distance between two instructions
`define INST_BYTES 32'd4

`endif

// File: rtl/branch.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module branch (
	input  wire logic rst,
	branch_if.unit    br
);

	cpu_pkg::opcode_t    opcode;
	logic [5:0]          funct;       // SPECIAL function field
	logic [25:0]         instr_index; // J-type index
	logic [15:0]         offset;      // I-type branch offset
	cpu_pkg::inst_addr_t pc_plus4;    // Delay slot address
	cpu_pkg::inst_addr_t target_i;    // Conditional branch target
	cpu_pkg::inst_addr_t target_j;    // Region-relative jump target
	logic                reg_equal;

	// Instruction fields
	assign opcode      = br.inst[31:26];
	assign funct       = br.inst[5:0];
	assign instr_index = br.inst[25:0];
	assign offset      = br.inst[15:0];

	// Targets are relative to the delay slot
	assign pc_plus4 = br.pc + `INST_BYTES;
	assign target_i = pc_plus4 + {{14{offset[15]}}, offset, 2'b00};
	assign target_j = {pc_plus4[31:28], instr_index, 2'b00}; // Stay in the 256MB region

	assign reg_equal = (br.reg1 == br.reg2);

	always_comb begin
		if (rst) begin
			br.is_branch = 1'b0;
			br.jump      = 1'b0;
			br.jump_to   = `ZERO_WORD;
		end else begin
			// Defaults for the conditional forms
			br.is_branch = 1'b1;
			br.jump      = 1'b0;
			br.jump_to   = target_i;
			case (opcode)
				cpu_pkg::OP_REGIMM: begin
					// Only rt codes 00000 00001 10000 10001 are branches
					br.is_branch = (br.inst[19:17] == 3'b000);
					// Sign of rs against bit 16 selects LTZ or GEZ
					br.jump = (br.reg1[31] ^ br.inst[16]) & br.is_branch;
				end
				cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE,
				cpu_pkg::OP_BLEZ, cpu_pkg::OP_BGTZ: begin
					// Bit 1 adds the sign test, bit 0 inverts
					br.jump = ((br.reg1[31] & opcode[1]) | reg_equal) ^ opcode[0];
				end
				cpu_pkg::OP_J, cpu_pkg::OP_JAL: begin
					br.jump    = 1'b1;
					br.jump_to = target_j;
				end
				cpu_pkg::OP_SPECIAL: begin
					if ((funct == cpu_pkg::FN_JR) || (funct == cpu_pkg::FN_JALR)) begin
						br.jump    = 1'b1;
						br.jump_to = br.reg1; // Register target
					end else begin
						// ALU ops and the rest of SPECIAL
						br.is_branch = 1'b0;
						br.jump_to   = `ZERO_WORD;
					end
				end
				default: begin
					br.is_branch = 1'b0;
					br.jump_to   = `ZERO_WORD;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/branch_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module branch_core #(
	parameter cpu_pkg::inst_addr_t RESET_PC = `DEFAULT_RESET_PC
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 run,
	input  wire logic                 cfg_we,
	input  wire cpu_pkg::reg_addr_t   cfg_addr,
	input  wire cpu_pkg::word_t       cfg_data,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output cpu_pkg::inst_addr_t       wb_adr,
	output logic [3:0]                wb_sel,
	output logic                      wb_we,
	input  wire cpu_pkg::word_t       wb_dat_i,
	input  wire logic                 wb_ack,
	output logic                      retire_valid,
	output cpu_pkg::inst_addr_t       retire_pc,
	output cpu_pkg::inst_t            retire_inst,
	output logic                      retire_jump,
	output cpu_pkg::inst_addr_t       retire_target
);

	cpu_pkg::reg_addr_t  ra1, ra2;     // Read indices
	logic                rf_we;
	cpu_pkg::reg_addr_t  rf_waddr;
	cpu_pkg::word_t      rf_wdata;
	logic                fetch_req, fetch_done;
	cpu_pkg::inst_addr_t fetch_addr;
	cpu_pkg::inst_t      fetch_word;

	branch_if br_if ();

	regfile u_regfile (.clk(clk), .rst(rst), .ra1(ra1), .ra2(ra2), .rd(br_if.rf),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata));

	branch u_branch (.rst(rst), .br(br_if.unit));

	wb_fetch u_fetch (.clk(clk), .rst(rst), .req(fetch_req), .addr(fetch_addr),
		.done(fetch_done), .word(fetch_word), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_adr(wb_adr), .wb_sel(wb_sel), .wb_we(wb_we), .wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack));

	pc_ctrl #(.RESET_PC(RESET_PC)) u_pc_ctrl (.clk(clk), .rst(rst), .run(run),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.req(fetch_req), .addr(fetch_addr), .done(fetch_done), .word(fetch_word),
		.ra1(ra1), .ra2(ra2), .br(br_if.ctrl),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
		.retire_valid(retire_valid), .retire_pc(retire_pc), .retire_inst(retire_inst),
		.retire_jump(retire_jump), .retire_target(retire_target));

endmodule

`default_nettype wire

// File: rtl/branch_if.sv
`timescale 1ns/100ps
`default_nettype none

// One instruction's operands towards the branch unit and its decision back
interface branch_if;

	cpu_pkg::inst_addr_t pc;        // Address of the instruction
	cpu_pkg::inst_t      inst;      // Instruction word
	cpu_pkg::word_t      reg1;      // rs value
	cpu_pkg::word_t      reg2;      // rt value
	logic                is_branch; // Control-flow instruction decoded
	logic                jump;      // Flow is redirected
	cpu_pkg::inst_addr_t jump_to;   // Redirect address

	// Sequencer side
	modport ctrl (output pc, inst, input is_branch, jump, jump_to);

	// Resolution logic
	modport unit (input pc, inst, reg1, reg2, output is_branch, jump, jump_to);

	// Register file read data
	modport rf (output reg1, reg2);

endinterface

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Vector widths with a meaning
	typedef logic [31:0] word_t;      // Register and link data
	typedef logic [31:0] inst_addr_t; // Byte address of an instruction
	typedef logic [31:0] inst_t;      // Raw instruction word
	typedef logic [4:0]  reg_addr_t;  // Register index
	typedef logic [5:0]  opcode_t;    // Primary opcode field

	// Primary opcodes of the control-flow subset
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_REGIMM  = 6'b000001; // BLTZ BGEZ BLTZAL BGEZAL
	localparam opcode_t OP_J       = 6'b000010;
	localparam opcode_t OP_JAL     = 6'b000011;
	localparam opcode_t OP_BEQ     = 6'b000100;
	localparam opcode_t OP_BNE     = 6'b000101;
	localparam opcode_t OP_BLEZ    = 6'b000110; // rt is zero
	localparam opcode_t OP_BGTZ    = 6'b000111; // rt is zero

	// SPECIAL function field codes
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_JALR = 6'b001001;

	// Return address register for JAL and the AL branches
	localparam reg_addr_t LINK_REG = 5'd31;

	// Sequencer states
	typedef enum logic [1:0] {
		IDLE,  // Stopped, config port owns the regfile
		FETCH, // Waiting on the bus
		EXEC   // One cycle, retire and link
	} seq_state_t;

endpackage

`default_nettype wire

// File: rtl/pc_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module pc_ctrl #(
	parameter cpu_pkg::inst_addr_t RESET_PC = `DEFAULT_RESET_PC
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 run,
	// Configuration write
	input  wire logic                 cfg_we,
	input  wire cpu_pkg::reg_addr_t   cfg_addr,
	input  wire cpu_pkg::word_t       cfg_data,
	// Fetch handshake
	output logic                      req,
	output cpu_pkg::inst_addr_t       addr,
	input  wire logic                 done,
	input  wire cpu_pkg::inst_t       word,
	// Register access
	output cpu_pkg::reg_addr_t        ra1,
	output cpu_pkg::reg_addr_t        ra2,
	branch_if.ctrl                    br,
	output logic                      we,
	output cpu_pkg::reg_addr_t        waddr,
	output cpu_pkg::word_t            wdata,
	// Retire port
	output logic                      retire_valid,
	output cpu_pkg::inst_addr_t       retire_pc,
	output cpu_pkg::inst_t            retire_inst,
	output logic                      retire_jump,
	output cpu_pkg::inst_addr_t       retire_target
);

	cpu_pkg::seq_state_t state;
	cpu_pkg::inst_addr_t pc;        // Address of the instruction in flight
	cpu_pkg::inst_t      inst_q;    // Fetched word
	logic                in_delay;  // Current instruction is a delay slot
	cpu_pkg::inst_addr_t pending;   // Target taken after the delay slot
	cpu_pkg::opcode_t    opcode;
	cpu_pkg::inst_addr_t next_pc;
	logic                taken;     // Redirect decided by this instruction
	logic                link_we;
	cpu_pkg::reg_addr_t  link_addr;

	assign opcode = inst_q[31:26];

	// Operands for the branch unit
	assign br.pc   = pc;
	assign br.inst = inst_q;
	assign ra1     = inst_q[25:21]; // rs
	assign ra2     = inst_q[20:16]; // rt, zero for BLEZ and BGTZ

	// Branches in a delay slot are plain no-ops
	assign taken = br.is_branch & br.jump & ~in_delay;

	// Next-pc rule
	always_comb begin
		if (in_delay) next_pc = pending;         // Leave the slot to the target
		else          next_pc = pc + `INST_BYTES; // Delay slot or sequential
	end

	// Link decode
	always_comb begin
		link_we   = 1'b0;
		link_addr = cpu_pkg::LINK_REG;
		case (opcode)
			cpu_pkg::OP_JAL:    link_we = 1'b1;
			cpu_pkg::OP_REGIMM: link_we = br.is_branch & inst_q[20]; // BLTZAL BGEZAL
			cpu_pkg::OP_SPECIAL: begin
				if (inst_q[5:0] == cpu_pkg::FN_JALR) begin
					link_we   = 1'b1;
					link_addr = inst_q[15:11]; // rd
				end
			end
			default: link_we = 1'b0;
		endcase
	end

	// Register write port owner
	always_comb begin
		if (state == cpu_pkg::EXEC) begin
			we    = link_we & ~in_delay; // Link regardless of taken
			waddr = link_addr;
			wdata = pc + (`INST_BYTES << 1);
		end else begin
			we    = cfg_we & ~run; // Config only while stopped
			waddr = cfg_addr;
			wdata = cfg_data;
		end
	end

	// Fetch request one cycle ahead of FETCH
	assign req  = run & ((state == cpu_pkg::IDLE) | (state == cpu_pkg::EXEC));
	assign addr = (state == cpu_pkg::EXEC) ? next_pc : pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= cpu_pkg::IDLE;
			pc       <= RESET_PC;
			inst_q   <= `ZERO_WORD;
			in_delay <= 1'b0;
			pending  <= `ZERO_WORD;
		end else begin
			case (state)
				cpu_pkg::IDLE: if (run) state <= cpu_pkg::FETCH;
				cpu_pkg::FETCH: begin
					if (done) begin
						inst_q <= word;
						state  <= cpu_pkg::EXEC;
					end
				end
				cpu_pkg::EXEC: begin
					pc       <= next_pc;
					in_delay <= taken;
					if (taken) pending <= br.jump_to;
					state <= run ? cpu_pkg::FETCH : cpu_pkg::IDLE; // Stop honored here only
				end
				default: state <= cpu_pkg::IDLE;
			endcase
		end
	end

	// Retire report
	assign retire_valid  = (state == cpu_pkg::EXEC);
	assign retire_pc     = pc;
	assign retire_inst   = inst_q;
	assign retire_jump   = taken;
	assign retire_target = taken ? br.jump_to : `ZERO_WORD;

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module regfile (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire cpu_pkg::reg_addr_t  ra1,   // rs index
	input  wire cpu_pkg::reg_addr_t  ra2,   // rt index
	branch_if.rf                     rd,    // Read data towards branch
	input  wire logic                we,
	input  wire cpu_pkg::reg_addr_t  waddr,
	input  wire cpu_pkg::word_t      wdata
);

	// One register per index value
	localparam int NREGS = 2 ** $bits(cpu_pkg::reg_addr_t);

	cpu_pkg::word_t regs [NREGS];

	// Single write port
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= `ZERO_WORD;
			end
		end else if (we && (waddr != '0)) begin // r0 writes dropped
			regs[waddr] <= wdata;
		end
	end

	// Combinational reads
	// r0 forced to zero on the read side as well
	always_comb begin
		rd.reg1 = (ra1 == '0) ? `ZERO_WORD : regs[ra1];
		rd.reg2 = (ra2 == '0) ? `ZERO_WORD : regs[ra2];
	end

endmodule

`default_nettype wire

// File: rtl/wb_fetch.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module wb_fetch (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 req,      // Start a read
	input  wire cpu_pkg::inst_addr_t  addr,     // Sampled with req
	output logic                      done,     // One cycle after ack
	output cpu_pkg::inst_t            word,     // Valid with done
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output cpu_pkg::inst_addr_t       wb_adr,
	output logic [3:0]                wb_sel,
	output logic                      wb_we,
	input  wire cpu_pkg::word_t       wb_dat_i,
	input  wire logic                 wb_ack
);

	// Bus cycle tracking
	typedef enum logic {
		BUS_IDLE,
		BUS_WAIT  // cyc held until ack
	} bus_state_t;

	bus_state_t state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= BUS_IDLE;
			wb_adr <= `ZERO_WORD;
			word   <= `ZERO_WORD;
			done   <= 1'b0;
		end else begin
			done <= 1'b0; // Pulse only
			case (state)
				BUS_IDLE: begin
					if (req) begin
						wb_adr <= addr; // Stable for the whole cycle
						state  <= BUS_WAIT;
					end
				end
				BUS_WAIT: begin
					// Wait states just keep us here
					if (wb_ack) begin
						word  <= wb_dat_i;
						done  <= 1'b1;
						state <= BUS_IDLE; // cyc drops next cycle
					end
				end
				default: state <= BUS_IDLE;
			endcase
		end
	end

	// cyc and stb move together
	assign wb_cyc = (state == BUS_WAIT);
	assign wb_stb = wb_cyc;
	assign wb_sel = 4'b1111; // Whole word always
	assign wb_we  = 1'b0;    // Read-only master

endmodule

`default_nettype wire
